//--- list.f
logic/lv_pkg.sv
logic/lv_spi_slv.sv
logic/lv_reg_slv.sv
logic/lv_pwm_mon.sv
logic/lv_ctrl_unit.sv
logic/lv_core.sv
verification/lv_core_asserts.sv
verification/lv_core_tb.sv

//--- logic/lv_core.sv
`timescale 1ns/1ps
/*
 * Top level of the lv core control path.
 * Connects the SPI slave, register slave, PWM monitor and control FSM.
 */
module lv_core (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_spi_sclk,
    input  logic            i_spi_csb,
    input  logic            i_spi_mosi,
    output logic            o_spi_miso,
    input  logic            i_lv_pwm_dt,
    input  logic            i_lv_gate_vs_pwm,
    input  logic            i_lv_vsup_ov,
    input  logic            i_lv_vsup_uv_n,
    input  lv_pkg::io_lvl_t i_io_lvl,
    output logic            o_dgt_ang_pwm_en,
    output logic            o_dgt_ang_fsc_en,
    output logic            o_intb_n
);
    import lv_pkg::*;

    reg_req_t    reg_req;
    reg_data_t   rd_data;
    mode_cmd_t   mode_cmd;
    mon_dly_t    mon_dly;
    lv_err_t     lv_err;
    lv_ctrl_st_e ctrl_st;
    logic        spi_err;
    logic        pwm_dterr;
    logic        pwm_mmerr;
    logic        err_any;
    logic        cfg_wr_en;

    // ============================================================
    // error pulses into status1
    // ============================================================
    assign lv_err.spi_err   = spi_err;
    assign lv_err.pwm_dterr = pwm_dterr;
    assign lv_err.pwm_mmerr = pwm_mmerr;

    lv_spi_slv #(
        .ADDR_W     (REG_AW),
        .DATA_W     (REG_DW)
    ) u_spi_slv (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_spi_sclk (i_spi_sclk),
        .i_spi_csb  (i_spi_csb),
        .i_spi_mosi (i_spi_mosi),
        .o_spi_miso (o_spi_miso),
        .o_reg_req  (reg_req),
        .i_rd_data  (rd_data),
        .o_spi_err  (spi_err)
    );

    lv_reg_slv u_reg_slv (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_reg_req   (reg_req),
        .o_rd_data   (rd_data),
        .i_err       (lv_err),
        .i_vsup_ov   (i_lv_vsup_ov),
        .i_vsup_uv_n (i_lv_vsup_uv_n),
        .i_io_lvl    (i_io_lvl),
        .i_ctrl_st   (ctrl_st),
        .i_cfg_wr_en (cfg_wr_en),
        .o_mode_cmd  (mode_cmd),
        .o_mon_dly   (mon_dly),
        .o_err_any   (err_any)
    );

    lv_pwm_mon #(
        .MON_DLY_W        (DLY_W)
    ) u_pwm_mon (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_lv_pwm_dt      (i_lv_pwm_dt),
        .i_lv_gate_vs_pwm (i_lv_gate_vs_pwm),
        .i_mon_dly        (mon_dly),
        .o_pwm_dterr      (pwm_dterr),
        .o_pwm_mmerr      (pwm_mmerr)
    );

    lv_ctrl_unit u_ctrl_unit (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_mode_cmd  (mode_cmd),
        .i_err_any   (err_any),
        .o_ctrl_st   (ctrl_st),
        .o_cfg_wr_en (cfg_wr_en),
        .o_pwm_en    (o_dgt_ang_pwm_en),
        .o_fsc_en    (o_dgt_ang_fsc_en),
        .o_intb_n    (o_intb_n)
    );

endmodule

//--- logic/lv_ctrl_unit.sv
`timescale 1ns/1ps
/*
 * Control FSM of the lv core: wait, configuration, normal and fault.
 * Enables are registered and decoded from the next state.
 */
module lv_ctrl_unit (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  lv_pkg::mode_cmd_t   i_mode_cmd,
    input  logic                i_err_any,
    output lv_pkg::lv_ctrl_st_e o_ctrl_st,
    output logic                o_cfg_wr_en,
    output logic                o_pwm_en,
    output logic                o_fsc_en,
    output logic                o_intb_n
);
    import lv_pkg::*;

    lv_ctrl_st_e st_q;
    lv_ctrl_st_e st_nxt;

    always_comb begin
        st_nxt = st_q;
        case (st_q)
            ST_WAIT: begin
                if (i_mode_cmd.cfg) st_nxt = ST_CFG;
            end
            ST_CFG: begin
                if (i_mode_cmd.normal) st_nxt = ST_NORMAL;
            end
            ST_NORMAL: begin
                if (i_err_any) st_nxt = ST_FAULT;
            end
            ST_FAULT:  st_nxt = ST_FAULT;  // left only by reset command
            default:   st_nxt = ST_WAIT;
        endcase
        if (i_mode_cmd.reset) st_nxt = ST_WAIT;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            st_q        <= ST_WAIT;
            o_cfg_wr_en <= 1'b1;
            o_pwm_en    <= 1'b0;
            o_fsc_en    <= 1'b0;
            o_intb_n    <= 1'b1;
        end else begin
            st_q        <= st_nxt;
            o_cfg_wr_en <= (st_nxt == ST_WAIT) || (st_nxt == ST_CFG);
            o_pwm_en    <= (st_nxt == ST_NORMAL);
            o_fsc_en    <= (st_nxt == ST_FAULT);
            o_intb_n    <= (st_nxt != ST_FAULT);  // active low interrupt
        end
    end

    assign o_ctrl_st = st_q;

endmodule

//--- logic/lv_pkg.sv
/*
 * Shared types for the lv core control path.
 * Holds the register map, request and status structs and the control states.
 * Modules import it inside their bodies and use scoped names on their ports.
 */
package lv_pkg;

    localparam int REG_AW = 7;
    localparam int REG_DW = 8;
    localparam int DLY_W  = 4;

    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [REG_DW-1:0] reg_data_t;
    typedef logic [DLY_W-1:0]  mon_dly_t;

    // register map
    localparam reg_addr_t ADDR_MODE    = 7'h00;
    localparam reg_addr_t ADDR_CONFIG0 = 7'h01;  // low bits are mismatch delay
    localparam reg_addr_t ADDR_STATUS1 = 7'h02;  // sticky, write 1 to clear
    localparam reg_addr_t ADDR_STATUS2 = 7'h03;
    localparam reg_addr_t ADDR_STATUS3 = 7'h04;
    localparam reg_addr_t ADDR_STATUS4 = 7'h05;

    typedef struct packed {
        logic      wr;
        logic      rd;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

    typedef struct packed {
        logic reset;   // bit 2
        logic normal;
        logic cfg;     // bit 0
    } mode_cmd_t;

    typedef struct packed {
        logic pwm_mmerr;
        logic pwm_dterr;
        logic spi_err;
    } lv_err_t;

    typedef struct packed {
        logic pwma;    // bit 5
        logic pwm;
        logic fsstate;
        logic fsenb_n;
        logic intb;
        logic inta;    // bit 0
    } io_lvl_t;

    typedef enum logic [2:0] {
        ST_WAIT   = 3'd0,
        ST_CFG    = 3'd1,
        ST_NORMAL = 3'd2,
        ST_FAULT  = 3'd3
    } lv_ctrl_st_e;

endpackage

//--- logic/lv_pwm_mon.sv
`timescale 1ns/1ps
/*
 * Gate and PWM monitor. Pulses a dead-time error on each rising edge of
 * the dead-time flag, and a mismatch error once the gate-versus-PWM flag
 * stays high longer than the configured delay.
 */
module lv_pwm_mon #(
    parameter int MON_DLY_W = 4
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_lv_pwm_dt,
    input  logic                 i_lv_gate_vs_pwm,
    input  logic [MON_DLY_W-1:0] i_mon_dly,
    output logic                 o_pwm_dterr,
    output logic                 o_pwm_mmerr
);

    logic [2:0]         dt_sync;
    logic [1:0]         mm_sync;
    logic               mm_s;
    logic [MON_DLY_W:0] mm_cnt;  // one bit wider so it saturates past any delay

    assign mm_s = mm_sync[1];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            dt_sync     <= '0;
            mm_sync     <= '0;
            mm_cnt      <= '0;
            o_pwm_dterr <= 1'b0;
            o_pwm_mmerr <= 1'b0;
        end else begin
            dt_sync     <= {dt_sync[1:0], i_lv_pwm_dt};
            mm_sync     <= {mm_sync[0], i_lv_gate_vs_pwm};
            o_pwm_dterr <= dt_sync[1] & ~dt_sync[2];
            o_pwm_mmerr <= mm_s & (mm_cnt == {1'b0, i_mon_dly});
            if (!mm_s) begin
                mm_cnt <= '0;  // short glitch restarts the count
            end else if (!(&mm_cnt)) begin
                mm_cnt <= mm_cnt + 1'b1;
            end
        end
    end

endmodule

//--- logic/lv_reg_slv.sv
`timescale 1ns/1ps
/*
 * LV register slave. Mode writes become one-cycle command strobes,
 * CONFIG0 is writable only while the control FSM allows it, status1
 * collects sticky errors and the other status registers read live.
 */
module lv_reg_slv (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  lv_pkg::reg_req_t    i_reg_req,
    output lv_pkg::reg_data_t   o_rd_data,
    input  lv_pkg::lv_err_t     i_err,
    input  logic                i_vsup_ov,
    input  logic                i_vsup_uv_n,
    input  lv_pkg::io_lvl_t     i_io_lvl,
    input  lv_pkg::lv_ctrl_st_e i_ctrl_st,
    input  logic                i_cfg_wr_en,
    output lv_pkg::mode_cmd_t   o_mode_cmd,
    output lv_pkg::mon_dly_t    o_mon_dly,
    output logic                o_err_any
);
    import lv_pkg::*;

    reg_data_t config0_q;
    lv_err_t   status1_q;
    lv_err_t   status1_clr;
    reg_data_t status2;
    logic      wr_mode;
    logic      wr_cfg0;
    logic      wr_sts1;

    // ============================================================
    // write decode
    // ============================================================
    assign wr_mode = i_reg_req.wr && (i_reg_req.addr == ADDR_MODE);
    assign wr_cfg0 = i_reg_req.wr && (i_reg_req.addr == ADDR_CONFIG0) && i_cfg_wr_en;
    assign wr_sts1 = i_reg_req.wr && (i_reg_req.addr == ADDR_STATUS1);

    assign status1_clr = wr_sts1 ? lv_err_t'(i_reg_req.wdata[$bits(lv_err_t)-1:0]) : '0;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            config0_q  <= '0;
            status1_q  <= '0;
            o_mode_cmd <= '0;
        end else begin
            o_mode_cmd <= wr_mode ? mode_cmd_t'(i_reg_req.wdata[$bits(mode_cmd_t)-1:0]) : '0;
            if (wr_cfg0) begin
                config0_q <= i_reg_req.wdata;
            end
            // a new pulse wins over a clear in the same cycle
            status1_q <= lv_err_t'((status1_q & ~status1_clr) | i_err);
        end
    end

    assign status2   = {{(REG_DW-2){1'b0}}, i_vsup_ov, ~i_vsup_uv_n};
    assign o_mon_dly = config0_q[DLY_W-1:0];
    assign o_err_any = (|status1_q) | (|status2);

    // ============================================================
    // read mux
    // ============================================================
    always_comb begin
        o_rd_data = '0;
        if (i_reg_req.rd) begin
            case (i_reg_req.addr)
                ADDR_CONFIG0: o_rd_data = config0_q;
                ADDR_STATUS1: o_rd_data = reg_data_t'(status1_q);
                ADDR_STATUS2: o_rd_data = status2;
                ADDR_STATUS3: o_rd_data = reg_data_t'(i_io_lvl);  // live pin levels
                ADDR_STATUS4: o_rd_data = reg_data_t'(i_ctrl_st);
                default:      o_rd_data = '0;  // mode reads back zero
            endcase
        end
    end

endmodule

//--- logic/lv_spi_slv.sv
`timescale 1ns/1ps
/*
 * SPI mode-0 slave, oversampled on i_clk through two sync flops.
 * Frame is write flag, address, data, MSB first. A read returns the
 * register byte in the data field of the same frame.
 */
module lv_spi_slv #(
    parameter int ADDR_W = 7,
    parameter int DATA_W = 8
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_spi_sclk,
    input  logic              i_spi_csb,
    input  logic              i_spi_mosi,
    output logic              o_spi_miso,
    output lv_pkg::reg_req_t  o_reg_req,
    input  lv_pkg::reg_data_t i_rd_data,
    output logic              o_spi_err
);

    localparam int HDR_W = ADDR_W + 1;
    localparam int FRM_W = HDR_W + DATA_W;
    localparam int CNT_W = $clog2(FRM_W) + 1;

    logic [2:0]        sclk_sync;
    logic [2:0]        csb_sync;
    logic [1:0]        mosi_sync;
    logic              csb_s;
    logic              sclk_rise;
    logic              sclk_fall;
    logic              csb_rise;
    logic              csb_fall;
    logic [CNT_W-1:0]  bit_cnt;
    logic [FRM_W-1:0]  shift_in;
    logic [DATA_W-1:0] shift_out;
    logic              hdr_done;
    logic              wr_stb;
    logic              tx_shift;

    // ============================================================
    // pin sync and edge detect
    // ============================================================
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            sclk_sync <= '0;
            csb_sync  <= '1;  // idle deselected
            mosi_sync <= '0;
        end else begin
            sclk_sync <= {sclk_sync[1:0], i_spi_sclk};
            csb_sync  <= {csb_sync[1:0], i_spi_csb};
            mosi_sync <= {mosi_sync[0], i_spi_mosi};
        end
    end

    assign csb_s     = csb_sync[1];
    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    assign csb_rise  = csb_sync[1] & ~csb_sync[2];
    assign csb_fall  = ~csb_sync[1] & csb_sync[2];
    assign tx_shift  = sclk_fall & ~csb_s & (bit_cnt >= CNT_W'(HDR_W));

    // ============================================================
    // bit count and request strobes
    // ============================================================
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            bit_cnt   <= '0;
            hdr_done  <= 1'b0;
            wr_stb    <= 1'b0;
            o_spi_err <= 1'b0;
        end else begin
            hdr_done  <= sclk_rise & ~csb_s & (bit_cnt == CNT_W'(HDR_W - 1));
            wr_stb    <= csb_rise & (bit_cnt == CNT_W'(FRM_W)) & shift_in[FRM_W-1];
            o_spi_err <= csb_rise & (bit_cnt != CNT_W'(FRM_W));  // short or long frame
            if (csb_fall) begin
                bit_cnt <= '0;
            end else if (sclk_rise && !csb_s && !(&bit_cnt)) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (sclk_rise && !csb_s) begin
            shift_in <= {shift_in[FRM_W-2:0], mosi_sync[1]};
        end
    end

    // read data goes out on falling edges after the header
    always_ff @(posedge i_clk) begin
        if (hdr_done) begin
            shift_out <= i_rd_data;
        end else if (tx_shift) begin
            shift_out <= {shift_out[DATA_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || csb_s) begin
            o_spi_miso <= 1'b0;
        end else if (tx_shift) begin
            o_spi_miso <= shift_out[DATA_W-1];
        end
    end

    always_comb begin
        o_reg_req.wr    = wr_stb;
        o_reg_req.rd    = hdr_done & ~shift_in[HDR_W-1];
        o_reg_req.addr  = wr_stb ? shift_in[FRM_W-2:DATA_W] : shift_in[ADDR_W-1:0];
        o_reg_req.wdata = shift_in[DATA_W-1:0];
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the lv core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module lv_core_tb -f list.f -o lv_core_sim || exit 1
out=$(./obj_dir/lv_core_sim +verilator+error+limit+100)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "^Verification passed$" && echo "PASS" || { echo "FAIL"; exit 1; }

//--- verification/lv_core_asserts.sv
`timescale 1ns/1ps
/*
 * Concurrent checks on the lv core enables, bound into lv_core.
 * The failure count is read by the testbench.
 */
module lv_core_asserts (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_pwm_en,
    input logic i_fsc_en,
    input logic i_intb_n
);

    int unsigned n_fail = 0;

    // pwm and fail-safe never together
    a_en_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_pwm_en && i_fsc_en))
        else begin
            n_fail++;
            $error("pwm_en and fsc_en both high");
        end

    a_intb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_intb_n == !i_fsc_en)  // interrupt follows fault
        else begin
            n_fail++;
            $error("intb_n does not match inverse of fsc_en");
        end

    a_rst_en: assert property (@(posedge i_clk) !i_rst_n |=> (!i_pwm_en && !i_fsc_en))
        else begin
            n_fail++;
            $error("enables not low after reset");
        end

endmodule

bind lv_core lv_core_asserts asserts_i (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_pwm_en (o_dgt_ang_pwm_en),
    .i_fsc_en (o_dgt_ang_fsc_en),
    .i_intb_n (o_intb_n)
);

//--- verification/lv_core_tb.sv
`timescale 1ns/1ps
/*
 * Testbench for the lv core control path. Drives SPI frames, supply,
 * IO and monitor inputs, and checks register readback and enables.
 */
module lv_core_tb;
    import lv_pkg::*;

    localparam int PHASE       = 4;  // i_clk cycles per sclk phase
    localparam int N_FRAMES    = 16;
    localparam int TIMEOUT_CYC = N_FRAMES * 16 * 8 + 2000;

    logic        clk;
    logic        rst_n;
    logic        spi_sclk;
    logic        spi_csb;
    logic        spi_mosi;
    logic        spi_miso;
    logic        pwm_dt;
    logic        gate_vs_pwm;
    logic        vsup_ov;
    logic        vsup_uv_n;
    io_lvl_t     io_lvl;
    logic        pwm_en;
    logic        fsc_en;
    logic        intb_n;
    logic [31:0] lcg_state;
    logic [7:0]  rd_val;
    logic [7:0]  cfg_val;
    logic [7:0]  new_cfg;
    logic [7:0]  rnd;
    int          dly;

    lv_core dut_i (
        .i_clk            (clk),
        .i_rst_n          (rst_n),
        .i_spi_sclk       (spi_sclk),
        .i_spi_csb        (spi_csb),
        .i_spi_mosi       (spi_mosi),
        .o_spi_miso       (spi_miso),
        .i_lv_pwm_dt      (pwm_dt),
        .i_lv_gate_vs_pwm (gate_vs_pwm),
        .i_lv_vsup_ov     (vsup_ov),
        .i_lv_vsup_uv_n   (vsup_uv_n),
        .i_io_lvl         (io_lvl),
        .o_dgt_ang_pwm_en (pwm_en),
        .o_dgt_ang_fsc_en (fsc_en),
        .o_intb_n         (intb_n)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ============================================================
    // helpers
    // ============================================================
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_byte(output logic [7:0] v);
        lcg_state = lcg_step(lcg_state);
        v = lcg_state[23:16];
    endtask

    task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] got);
        assert (got === exp) else begin
            $display("Error at %0d ns: %s expected 0x%02h, got 0x%02h", $time, name, exp, got);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // mode 0 frame, mosi changes while sclk is low, miso read before each rise
    task automatic spi_frame(input logic [15:0] tx, input int nbits, output logic [7:0] rx);
        int i;
        rx = '0;
        @(negedge clk);
        spi_csb  = 1'b0;
        spi_mosi = tx[15];
        repeat (PHASE) @(negedge clk);
        for (i = 0; i < nbits; i++) begin
            if (i >= 8) rx = {rx[6:0], spi_miso};
            spi_sclk = 1'b1;
            repeat (PHASE) @(negedge clk);
            spi_sclk = 1'b0;
            if (i < 15) spi_mosi = tx[14-i];
            repeat (PHASE) @(negedge clk);
        end
        spi_csb = 1'b1;
        repeat (2 * PHASE) @(negedge clk);  // write lands well inside this gap
    endtask

    task automatic spi_write(input reg_addr_t addr, input reg_data_t data);
        logic [7:0] unused_rx;
        spi_frame({1'b1, addr, data}, 16, unused_rx);
    endtask

    task automatic spi_read(input reg_addr_t addr, output reg_data_t data);
        spi_frame({1'b0, addr, 8'h00}, 16, data);
    endtask

    // watchdog
    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Error: run did not finish within %0d clock cycles", TIMEOUT_CYC);
        $display("Verification failed");
        $fatal(1);
    end

    always @(negedge clk) begin
        if (dut_i.asserts_i.n_fail != 0) begin
            $display("Error at %0d ns: a bound assertion on lv_core failed", $time);
            $display("Verification failed");
            $fatal(1);
        end
    end

    // ============================================================
    // stimulus
    // ============================================================
    initial begin
        rst_n       = 1'b0;
        spi_sclk    = 1'b0;
        spi_csb     = 1'b1;
        spi_mosi    = 1'b0;
        pwm_dt      = 1'b0;
        gate_vs_pwm = 1'b0;
        vsup_ov     = 1'b0;
        vsup_uv_n   = 1'b1;
        io_lvl      = '0;
        lcg_state   = 32'h82b11c0a;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        // config0 in WAIT, then live status3 and status2
        draw_byte(cfg_val);
        cfg_val[3] = 1'b1;  // delay of 8 or more
        spi_write(ADDR_CONFIG0, cfg_val);
        spi_read(ADDR_CONFIG0, rd_val);
        check_val("config0", cfg_val, rd_val);
        draw_byte(rnd);
        io_lvl    = io_lvl_t'(rnd[5:0]);
        vsup_ov   = rnd[6];
        vsup_uv_n = rnd[7];
        spi_read(ADDR_STATUS3, rd_val);
        check_val("status3", {2'b00, rnd[5:0]}, rd_val);
        spi_read(ADDR_STATUS2, rd_val);
        check_val("status2", {6'd0, rnd[6], ~rnd[7]}, rd_val);
        vsup_ov   = 1'b0;
        vsup_uv_n = 1'b1;

        // short frame sets spi_err, dead-time edge sets pwm_dterr, write 1 clears
        pwm_dt = 1'b1;
        repeat (4) @(negedge clk);
        pwm_dt = 1'b0;
        spi_frame({1'b0, ADDR_STATUS4, 8'h00}, 12, rd_val);
        spi_read(ADDR_STATUS1, rd_val);
        check_val("status1", 8'h03, rd_val);
        spi_write(ADDR_STATUS1, 8'h03);
        spi_read(ADDR_STATUS1, rd_val);
        check_val("status1", 8'h00, rd_val);

        // cfg then normal
        spi_write(ADDR_MODE, 8'h01);
        spi_write(ADDR_MODE, 8'h02);
        check_val("o_dgt_ang_pwm_en", 8'd1, {7'd0, pwm_en});
        spi_read(ADDR_STATUS4, rd_val);
        check_val("status4", 8'd2, rd_val);
        draw_byte(new_cfg);
        if (new_cfg == cfg_val) new_cfg = ~new_cfg;
        spi_write(ADDR_CONFIG0, new_cfg);  // locked in NORMAL
        spi_read(ADDR_CONFIG0, rd_val);
        check_val("config0", cfg_val, rd_val);

        // mismatch filter, short high passes, long high faults
        dly = int'(cfg_val[3:0]);
        gate_vs_pwm = 1'b1;
        repeat (dly - 2) @(negedge clk);
        gate_vs_pwm = 1'b0;
        repeat (10) @(negedge clk);
        check_val("o_dgt_ang_pwm_en", 8'd1, {7'd0, pwm_en});
        gate_vs_pwm = 1'b1;
        repeat (dly + 6) @(negedge clk);
        gate_vs_pwm = 1'b0;
        repeat (10) @(negedge clk);
        check_val("o_dgt_ang_fsc_en", 8'd1, {7'd0, fsc_en});
        check_val("o_intb_n", 8'd0, {7'd0, intb_n});
        check_val("o_dgt_ang_pwm_en", 8'd0, {7'd0, pwm_en});
        spi_read(ADDR_STATUS1, rd_val);
        check_val("status1", 8'h04, rd_val);

        // reset command back to WAIT
        spi_write(ADDR_MODE, 8'h04);
        check_val("o_dgt_ang_pwm_en", 8'd0, {7'd0, pwm_en});
        check_val("o_dgt_ang_fsc_en", 8'd0, {7'd0, fsc_en});
        spi_read(ADDR_STATUS4, rd_val);
        check_val("status4", 8'd0, rd_val);

        repeat (4) @(negedge clk);
        if (dut_i.asserts_i.n_fail != 0) begin
            $display("Error at %0d ns: bound assertions failed %0d times", $time,
                     dut_i.asserts_i.n_fail);
            $display("Verification failed");
            $fatal(1);
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule
